// File: all.f
+incdir+rtl
rtl/streamer_pkg.sv
rtl/stream_source.sv
rtl/stream_sink.sv
rtl/tcdm_arbiter.sv
rtl/streamer_top.sv
dv/tb_clk_gen.sv
dv/streamer_tb.sv

// File: dv/streamer_tb.sv
`timescale 1ns/1ps
`include "streamer_params.svh"

module streamer_tb;

  localparam int unsigned MEM_WORDS = 1024;
  localparam logic [31:0] FILL_KEY  = 32'h3c5a_96e1;
  localparam int unsigned GNT_PCT   = 70;
  localparam int unsigned ROWS      = 6;
  // Cycle of a row at which clear hits, for rows that abort
  localparam int          CLEAR_AT  = 12;

  // One test case, X W Z setup plus ready throttle and mid run clear
  typedef struct packed {
    streamer_pkg::stream_ctrl_t x;
    streamer_pkg::stream_ctrl_t w;
    streamer_pkg::stream_ctrl_t z;
    logic [7:0]                 ready_pct;
    logic                       clear;
  } row_t;

  logic                        clk;
  logic                        arst_n;
  logic                        clear;
  // Channel index 0 is X, 1 is W, 2 is Z
  logic                        start    [3];
  streamer_pkg::stream_ctrl_t  ctrl     [3];
  streamer_pkg::stream_flags_t flags    [3];
  streamer_pkg::stream_t       ld_stream[2];
  logic                        ready    [2];
  streamer_pkg::stream_t       z_stream;
  logic                        z_ready;
  streamer_pkg::tcdm_req_t     mem_req;
  streamer_pkg::tcdm_rsp_t     mem_rsp;

  // Memory model and its expected image
  logic [`STREAMER_DW-1:0] mem     [MEM_WORDS];
  logic [`STREAMER_DW-1:0] ref_mem [MEM_WORDS];
  row_t                    rows    [ROWS];
  logic                    rows_ready;
  // Read accepted on the coming edge, answered the cycle after
  logic                    rd_due;
  logic [`STREAMER_DW-1:0] rd_data;
  int                      cnt     [3];
  int                      dones   [3];
  logic                    due     [3];
  logic                    z_moved;
  int                      row_idx;

  tb_clk_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

  streamer_top DUT (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .clear_i    (clear),
    .x_start_i  (start[0]),
    .w_start_i  (start[1]),
    .z_start_i  (start[2]),
    .x_ctrl_i   (ctrl[0]),
    .w_ctrl_i   (ctrl[1]),
    .z_ctrl_i   (ctrl[2]),
    .x_stream_o (ld_stream[0]),
    .w_stream_o (ld_stream[1]),
    .x_ready_i  (ready[0]),
    .w_ready_i  (ready[1]),
    .z_stream_i (z_stream),
    .z_ready_o  (z_ready),
    .x_flags_o  (flags[0]),
    .w_flags_o  (flags[1]),
    .z_flags_o  (flags[2]),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp)
  );

  // Initial content, word address XOR a fixed key
  function automatic logic [31:0] fill_word(input logic [31:0] widx);
    return widx ^ FILL_KEY;
  endfunction

  // Z beat k of row r, a row tagged counter
  function automatic logic [31:0] z_beat(input int r, input int k);
    return {8'(r), 8'ha5, 16'(k)};
  endfunction

  function automatic streamer_pkg::stream_ctrl_t mk(input logic [31:0] base,
      input logic [31:0] stride, input logic [15:0] len);
    return {base, stride, len};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp));
    end
  endtask

  // Falling edge drive of memory answer, ready throttle and Z beat
  task automatic drive_cycle(input row_t rw, input logic on);
    @(negedge clk);
    mem_rsp.gnt     = ($urandom_range(99) < GNT_PCT);
    mem_rsp.r_valid = rd_due;
    mem_rsp.r_data  = rd_data;
    ready[0] = on && ($urandom_range(99) < 32'(rw.ready_pct));
    ready[1] = on && ($urandom_range(99) < 32'(rw.ready_pct));
    // Z valid stays up until its beat moves
    if (!z_stream.valid || z_moved) begin
      z_stream.valid = on && (cnt[2] < int'(rw.z.len)) && ($urandom_range(99) < 75);
      z_stream.data  = z_beat(row_idx, cnt[2]);
    end
  endtask

  // Sample just before the rising edge, after all inputs settled
  task automatic sample_cycle();
    logic [31:0] exp_addr;
    logic        acc;
    #1;
    acc = mem_req.req && mem_rsp.gnt;
    if (acc && (mem_req.addr[31:12] != '0)) begin
      abort_run($sformatf("Memory access outside the model at address %h", mem_req.addr));
    end
    // Done exactly one cycle after the last beat or write
    for (int c = 0; c < 3; c++) begin
      check_eq(32'(flags[c].done), 32'(due[c]), $sformatf("channel %0d done timing", c));
      if (flags[c].done) begin
        check_eq(32'(flags[c].busy), 32'h0, $sformatf("channel %0d busy at done", c));
      end
      dones[c] = dones[c] + int'(flags[c].done);
      due[c]   = 1'b0;
    end
    for (int c = 0; c < 2; c++) begin
      if (ld_stream[c].valid && ready[c]) begin
        if (cnt[c] >= int'(ctrl[c].len)) begin
          abort_run($sformatf("Load channel %0d sent a beat beyond its length", c));
        end
        exp_addr = ctrl[c].base + 32'(cnt[c]) * ctrl[c].stride;
        check_eq(ld_stream[c].data, fill_word(exp_addr >> 2),
                 $sformatf("channel %0d beat %0d", c, cnt[c]));
        cnt[c]++;
        due[c] = (cnt[c] == int'(ctrl[c].len));
      end
    end
    // A Z beat moves exactly with its granted write
    z_moved = z_stream.valid && z_ready;
    check_eq(32'(z_moved), 32'(acc && !mem_req.wen), "Z beat against memory write");
    if (acc && !mem_req.wen) begin
      if (cnt[2] >= int'(ctrl[2].len)) begin
        abort_run("Store channel wrote more words than its length");
      end
      exp_addr = ctrl[2].base + 32'(cnt[2]) * ctrl[2].stride;
      check_eq(mem_req.addr, exp_addr, "Z write address");
      check_eq(mem_req.data, z_beat(row_idx, cnt[2]), "Z write data");
      check_eq(32'(mem_req.be), 32'hf, "Z byte enables");
      ref_mem[exp_addr[11:2]] = z_beat(row_idx, cnt[2]);
      mem[mem_req.addr[11:2]] = mem_req.data;
      cnt[2]++;
      due[2] = (cnt[2] == int'(ctrl[2].len));
    end
    rd_due = acc && mem_req.wen;
    if (rd_due) begin
      rd_data = mem[mem_req.addr[11:2]];
    end
  endtask

  task automatic run_row(input int r);
    row_t rw;
    int   cyc;
    rw      = rows[r];
    row_idx = r;
    for (int c = 0; c < 3; c++) begin
      cnt[c]   = 0;
      dones[c] = 0;
      due[c]   = 1'b0;
    end
    // All three channels start together
    drive_cycle(rw, 1'b1);
    ctrl[0] = rw.x;
    ctrl[1] = rw.w;
    ctrl[2] = rw.z;
    for (int c = 0; c < 3; c++) start[c] = 1'b1;
    sample_cycle();
    drive_cycle(rw, 1'b1);
    for (int c = 0; c < 3; c++) start[c] = 1'b0;
    sample_cycle();
    for (int c = 0; c < 3; c++) begin
      check_eq(32'(flags[c].busy), 32'h1, $sformatf("row %0d channel %0d busy after start", r, c));
    end
    cyc = 0;
    while (!((dones[0] == 1) && (dones[1] == 1) && (dones[2] == 1)) &&
           !(rw.clear && (cyc == CLEAR_AT))) begin
      drive_cycle(rw, 1'b1);
      sample_cycle();
      cyc++;
    end
    if (rw.clear) begin
      drive_cycle(rw, 1'b0);
      // Abort withdraws the pending Z beat
      z_stream.valid = 1'b0;
      clear          = 1'b1;
      sample_cycle();
      drive_cycle(rw, 1'b0);
      clear = 1'b0;
      for (int c = 0; c < 3; c++) due[c] = 1'b0;
      sample_cycle();
      for (int c = 0; c < 3; c++) begin
        check_eq(32'(flags[c].busy), 32'h0, $sformatf("channel %0d busy after clear", c));
      end
    end
    // Quiet cycles, nothing may move and no done may repeat
    repeat (4) begin
      drive_cycle(rw, 1'b0);
      sample_cycle();
    end
    if (!rw.clear) begin
      for (int c = 0; c < 3; c++) begin
        check_eq(32'(cnt[c]), 32'(ctrl[c].len), $sformatf("row %0d channel %0d beats", r, c));
        check_eq(32'(dones[c]), 32'h1, $sformatf("row %0d channel %0d done count", r, c));
      end
      for (int k = 0; k < int'(rw.z.len); k++) begin
        check_eq(mem[10'((rw.z.base + 32'(k) * rw.z.stride) >> 2)], z_beat(r, k),
                 $sformatf("row %0d Z word %0d in memory", r, k));
      end
    end
    for (int i = 0; i < int'(MEM_WORDS); i++) begin
      check_eq(mem[i], ref_mem[i], $sformatf("memory word %0d after row %0d", i, r));
    end
  endtask

  initial begin
    void'($urandom(32'he00e_a960));
    rows_ready = 1'b0;
    clear      = 1'b0;
    z_stream   = '0;
    mem_rsp    = '0;
    rd_due     = 1'b0;
    rd_data    = '0;
    z_moved    = 1'b0;
    row_idx    = 0;
    for (int c = 0; c < 3; c++) begin
      start[c] = 1'b0;
      ctrl[c]  = '0;
      cnt[c]   = 0;
      dones[c] = 0;
      due[c]   = 1'b0;
    end
    ready[0] = 1'b0;
    ready[1] = 1'b0;
    for (int i = 0; i < int'(MEM_WORDS); i++) begin
      mem[i]     = fill_word(32'(i));
      ref_mem[i] = fill_word(32'(i));
    end
    // Loads stay below 0x800, stores above, so reads always see initial words
    rows[0] = {mk(32'h000, 32'd4, 16'd8), mk(32'h100, 32'd8, 16'd6),
               mk(32'h800, 32'd4, 16'd8), 8'd100, 1'b0};
    rows[1] = {mk(32'h040, 32'd12, 16'd10), mk(32'h200, 32'd4, 16'd12),
               mk(32'h900, 32'd8, 16'd10), 8'd50, 1'b0};
    rows[2] = {mk(32'h300, 32'd16, 16'd5), mk(32'h010, 32'd20, 16'd7),
               mk(32'ha00, 32'd12, 16'd6), 8'd30, 1'b0};
    rows[3] = {mk(32'h000, 32'd4, 16'd16), mk(32'h100, 32'd4, 16'd16),
               mk(32'hb00, 32'd4, 16'd16), 8'd70, 1'b1};
    rows[4] = {mk(32'h180, 32'd8, 16'd9), mk(32'h280, 32'd24, 16'd4),
               mk(32'hc00, 32'd16, 16'd9), 8'd80, 1'b0};
    rows[5] = {mk(32'h020, 32'd4, 16'd1), mk(32'h1f0, 32'd4, 16'd3),
               mk(32'he00, 32'd4, 16'd12), 8'd60, 1'b0};
    rows_ready = 1'b1;
    wait (arst_n === 1'b1);
    #1;
    // Quiet state out of reset
    for (int c = 0; c < 3; c++) begin
      check_eq(32'(flags[c].busy), 32'h0, $sformatf("channel %0d busy after reset", c));
      check_eq(32'(flags[c].done), 32'h0, $sformatf("channel %0d done after reset", c));
    end
    check_eq(32'(mem_req.req), 32'h0, "memory req after reset");
    check_eq(32'(ld_stream[0].valid), 32'h0, "X valid after reset");
    check_eq(32'(ld_stream[1].valid), 32'h0, "W valid after reset");
    for (int r = 0; r < int'(ROWS); r++) begin
      run_row(r);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  // Watchdog, 40 cycles per word of the whole table
  initial begin
    int unsigned words;
    words = 0;
    wait (rows_ready === 1'b1);
    for (int r = 0; r < int'(ROWS); r++) begin
      words += 32'(rows[r].x.len) + 32'(rows[r].w.len) + 32'(rows[r].z.len);
    end
    repeat (40 * words + 100) @(posedge clk);
    abort_run("Watchdog expired, the streams did not finish in time");
  end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 4 ns period
  localparam int unsigned HALF_PERIOD = 2;
  localparam int unsigned RST_CYCLES  = 3;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset held over three rising edges, released on a falling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: rtl/stream_sink.sv
`timescale 1ns/1ps
`include "streamer_params.svh"

module stream_sink (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        clear_i,
  input  logic                        start_i,
  input  streamer_pkg::stream_ctrl_t  ctrl_i,
  input  streamer_pkg::stream_t       stream_i,
  output logic                        stream_ready_o,
  output streamer_pkg::tcdm_req_t     tcdm_req_o,
  input  streamer_pkg::tcdm_rsp_t     tcdm_rsp_i,
  output streamer_pkg::stream_flags_t flags_o
);

  streamer_pkg::chan_state_e  state_q;
  logic [`STREAMER_AW-1:0]    addr_q;
  logic [`STREAMER_AW-1:0]    stride_q;
  // Words still to be written
  logic [`STREAMER_LEN_W-1:0] remain_q;
  logic                       done_q;
  logic                       wr_accept;

  // One beat becomes one full word write
  always_comb begin
    tcdm_req_o      = '0;
    tcdm_req_o.req  = (state_q == streamer_pkg::CHAN_RUN) && stream_i.valid;
    tcdm_req_o.addr = addr_q;
    tcdm_req_o.wen  = 1'b0;
    tcdm_req_o.be   = '1;
    tcdm_req_o.data = stream_i.data;
  end

  // Beat moves exactly when the write is granted
  assign stream_ready_o = tcdm_rsp_i.gnt;
  assign wr_accept      = tcdm_req_o.req && tcdm_rsp_i.gnt;

  assign flags_o.busy = (state_q == streamer_pkg::CHAN_RUN);
  assign flags_o.done = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= streamer_pkg::CHAN_IDLE;
      remain_q <= '0;
      done_q   <= 1'b0;
    end else if (clear_i) begin
      state_q  <= streamer_pkg::CHAN_IDLE;
      remain_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if ((state_q == streamer_pkg::CHAN_IDLE) && start_i) begin
        remain_q <= ctrl_i.len;
        if (ctrl_i.len != '0) state_q <= streamer_pkg::CHAN_RUN;
        else done_q <= 1'b1;
      end else if (wr_accept) begin
        remain_q <= remain_q - 1'b1;
        // Last write granted, finish on this edge
        if (remain_q == 1) begin
          state_q <= streamer_pkg::CHAN_IDLE;
          done_q  <= 1'b1;
        end
      end
    end
  end

  // Address walk by stride per granted write
  always_ff @(posedge clk_i) begin
    if ((state_q == streamer_pkg::CHAN_IDLE) && start_i) begin
      addr_q   <= ctrl_i.base;
      stride_q <= ctrl_i.stride;
    end else if (wr_accept) begin
      addr_q <= addr_q + stride_q;
    end
  end

  // Grant only ever lands on a live request of a running channel
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tcdm_rsp_i.gnt |-> tcdm_req_o.req && (state_q == streamer_pkg::CHAN_RUN))
    else $error("stream_sink: grant outside a running request");

endmodule

// File: rtl/stream_source.sv
`timescale 1ns/1ps
`include "streamer_params.svh"

module stream_source (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        clear_i,
  input  logic                        start_i,
  input  streamer_pkg::stream_ctrl_t  ctrl_i,
  output streamer_pkg::tcdm_req_t     tcdm_req_o,
  input  streamer_pkg::tcdm_rsp_t     tcdm_rsp_i,
  output streamer_pkg::stream_t       stream_o,
  input  logic                        stream_ready_i,
  output streamer_pkg::stream_flags_t flags_o
);

  localparam int unsigned DEPTH = `STREAMER_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  streamer_pkg::chan_state_e  state_q;
  logic [`STREAMER_AW-1:0]    addr_q;
  logic [`STREAMER_AW-1:0]    stride_q;
  logic [`STREAMER_LEN_W-1:0] len_q;
  logic [`STREAMER_LEN_W-1:0] req_cnt_q;
  logic [`STREAMER_LEN_W-1:0] beat_cnt_q;
  logic                       done_q;

  // Response FIFO
  logic [`STREAMER_DW-1:0] fifo_mem [DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [CNT_W-1:0]        count_q;
  // Reads granted whose data has not come back yet
  logic [CNT_W-1:0]        pending_q;
  logic [CNT_W-1:0]        free_slots;

  logic issue;
  logic rd_accept;
  logic push;
  logic pop;
  logic last_beat;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Credit check, every read in flight already owns a slot
  assign free_slots = CNT_W'(DEPTH) - count_q;
  assign issue      = (state_q == streamer_pkg::CHAN_RUN) && (req_cnt_q != len_q) &&
                      (free_slots > pending_q);
  assign rd_accept  = issue && tcdm_rsp_i.gnt;
  assign push       = tcdm_rsp_i.r_valid;
  assign pop        = stream_o.valid && stream_ready_i;
  assign last_beat  = pop && (beat_cnt_q == len_q - 1'b1);

  // Full word reads only
  always_comb begin
    tcdm_req_o      = '0;
    tcdm_req_o.req  = issue;
    tcdm_req_o.addr = addr_q;
    tcdm_req_o.wen  = 1'b1;
    tcdm_req_o.be   = '1;
  end

  // Head of the FIFO is the stream output
  assign stream_o.valid = (count_q != '0);
  assign stream_o.data  = fifo_mem[rd_ptr_q];

  assign flags_o.busy = (state_q == streamer_pkg::CHAN_RUN);
  assign flags_o.done = done_q;

  // Channel FSM and beat counters
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= streamer_pkg::CHAN_IDLE;
      req_cnt_q  <= '0;
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else if (clear_i) begin
      state_q    <= streamer_pkg::CHAN_IDLE;
      req_cnt_q  <= '0;
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        streamer_pkg::CHAN_IDLE: begin
          if (start_i) begin
            req_cnt_q  <= '0;
            beat_cnt_q <= '0;
            // Empty transfer finishes at once
            if (ctrl_i.len != '0) state_q <= streamer_pkg::CHAN_RUN;
            else done_q <= 1'b1;
          end
        end
        default: begin
          if (rd_accept) req_cnt_q <= req_cnt_q + 1'b1;
          if (pop) beat_cnt_q <= beat_cnt_q + 1'b1;
          if (last_beat) begin
            state_q <= streamer_pkg::CHAN_IDLE;
            done_q  <= 1'b1;
          end
        end
      endcase
    end
  end

  // Setup capture and address walk
  always_ff @(posedge clk_i) begin
    if (start_i && (state_q == streamer_pkg::CHAN_IDLE)) begin
      addr_q   <= ctrl_i.base;
      stride_q <= ctrl_i.stride;
      len_q    <= ctrl_i.len;
    end else if (rd_accept) begin
      addr_q <= addr_q + stride_q;
    end
  end

  // FIFO pointers, occupancy and read credits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      pending_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      pending_q <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q   <= count_q + CNT_W'(push) - CNT_W'(pop);
      pending_q <= pending_q + CNT_W'(rd_accept) - CNT_W'(push);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) fifo_mem[wr_ptr_q] <= tcdm_rsp_i.r_data;
  end

  // Credits must keep returning data from overrunning the FIFO
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push && !pop |-> count_q < CNT_W'(DEPTH))
    else $error("stream_source: response FIFO overflow");

  // Arbiter routes read data only to the channel that issued the read
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tcdm_rsp_i.r_valid |-> pending_q != '0)
    else $error("stream_source: read data with no read outstanding");

endmodule

// File: rtl/streamer_params.svh
`ifndef STREAMER_PARAMS_SVH
`define STREAMER_PARAMS_SVH

// Width of one memory word and of one stream beat
`define STREAMER_DW 32

// Byte address width on the memory port
`define STREAMER_AW 32

// Word count width, bounds the length of one transfer
`define STREAMER_LEN_W 16

// Entries in each load response FIFO
// Covers the memory turnaround with room to spare
`define STREAMER_FIFO_DEPTH 4

`endif

// File: rtl/streamer_pkg.sv
`include "streamer_params.svh"

package streamer_pkg;

  // One request on the memory port
  // wen high means read, low means write
  typedef struct packed {
    logic                      req;
    logic [`STREAMER_AW-1:0]   addr;
    logic                      wen;
    logic [`STREAMER_DW/8-1:0] be;
    logic [`STREAMER_DW-1:0]   data;
  } tcdm_req_t;

  // Memory answer, gnt in the request cycle, read data one cycle later
  typedef struct packed {
    logic                    gnt;
    logic                    r_valid;
    logic [`STREAMER_DW-1:0] r_data;
  } tcdm_rsp_t;

  // Forward half of a valid/ready stream
  typedef struct packed {
    logic                    valid;
    logic [`STREAMER_DW-1:0] data;
  } stream_t;

  // Per channel setup, stride in bytes
  typedef struct packed {
    logic [`STREAMER_AW-1:0]    base;
    logic [`STREAMER_AW-1:0]    stride;
    logic [`STREAMER_LEN_W-1:0] len;
  } stream_ctrl_t;

  // Busy is a level, done a single cycle pulse
  typedef struct packed {
    logic busy;
    logic done;
  } stream_flags_t;

  typedef enum logic {CHAN_IDLE, CHAN_RUN} chan_state_e;

  typedef enum logic [1:0] {OWNER_NONE, OWNER_X, OWNER_W, OWNER_Z} grant_owner_e;

endpackage

// File: rtl/streamer_top.sv
`timescale 1ns/1ps

module streamer_top (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        clear_i,
  input  logic                        x_start_i,
  input  logic                        w_start_i,
  input  logic                        z_start_i,
  input  streamer_pkg::stream_ctrl_t  x_ctrl_i,
  input  streamer_pkg::stream_ctrl_t  w_ctrl_i,
  input  streamer_pkg::stream_ctrl_t  z_ctrl_i,
  output streamer_pkg::stream_t       x_stream_o,
  output streamer_pkg::stream_t       w_stream_o,
  input  logic                        x_ready_i,
  input  logic                        w_ready_i,
  input  streamer_pkg::stream_t       z_stream_i,
  output logic                        z_ready_o,
  output streamer_pkg::stream_flags_t x_flags_o,
  output streamer_pkg::stream_flags_t w_flags_o,
  output streamer_pkg::stream_flags_t z_flags_o,
  output streamer_pkg::tcdm_req_t     mem_req_o,
  input  streamer_pkg::tcdm_rsp_t     mem_rsp_i
);

  // Channel side of the arbiter
  streamer_pkg::tcdm_req_t x_req;
  streamer_pkg::tcdm_req_t w_req;
  streamer_pkg::tcdm_req_t z_req;
  streamer_pkg::tcdm_rsp_t x_rsp;
  streamer_pkg::tcdm_rsp_t w_rsp;
  streamer_pkg::tcdm_rsp_t z_rsp;

  // X load channel
  stream_source u_x_source (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .clear_i        (clear_i),
    .start_i        (x_start_i),
    .ctrl_i         (x_ctrl_i),
    .tcdm_req_o     (x_req),
    .tcdm_rsp_i     (x_rsp),
    .stream_o       (x_stream_o),
    .stream_ready_i (x_ready_i),
    .flags_o        (x_flags_o)
  );

  // W load channel, same block as X
  stream_source u_w_source (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .clear_i        (clear_i),
    .start_i        (w_start_i),
    .ctrl_i         (w_ctrl_i),
    .tcdm_req_o     (w_req),
    .tcdm_rsp_i     (w_rsp),
    .stream_o       (w_stream_o),
    .stream_ready_i (w_ready_i),
    .flags_o        (w_flags_o)
  );

  // Z store channel
  stream_sink u_z_sink (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .clear_i        (clear_i),
    .start_i        (z_start_i),
    .ctrl_i         (z_ctrl_i),
    .stream_i       (z_stream_i),
    .stream_ready_o (z_ready_o),
    .tcdm_req_o     (z_req),
    .tcdm_rsp_i     (z_rsp),
    .flags_o        (z_flags_o)
  );

  // Three sources onto the single memory port
  tcdm_arbiter u_arbiter (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .clear_i   (clear_i),
    .x_req_i   (x_req),
    .w_req_i   (w_req),
    .z_req_i   (z_req),
    .x_rsp_o   (x_rsp),
    .w_rsp_o   (w_rsp),
    .z_rsp_o   (z_rsp),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
  );

endmodule

// File: rtl/tcdm_arbiter.sv
`timescale 1ns/1ps

module tcdm_arbiter (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    clear_i,
  input  streamer_pkg::tcdm_req_t x_req_i,
  input  streamer_pkg::tcdm_req_t w_req_i,
  input  streamer_pkg::tcdm_req_t z_req_i,
  output streamer_pkg::tcdm_rsp_t x_rsp_o,
  output streamer_pkg::tcdm_rsp_t w_rsp_o,
  output streamer_pkg::tcdm_rsp_t z_rsp_o,
  output streamer_pkg::tcdm_req_t mem_req_o,
  input  streamer_pkg::tcdm_rsp_t mem_rsp_i
);

  streamer_pkg::grant_owner_e sel;
  // Load left waiting on the port last cycle
  streamer_pkg::grant_owner_e lock_q;
  // Owner of the read whose data returns this cycle
  streamer_pkg::grant_owner_e rd_owner_q;
  // High when W goes first on the next X/W tie
  logic                       rr_w_q;
  logic                       accepted;

  always_comb begin
    sel = streamer_pkg::OWNER_NONE;
    // A presented load stays on the port until granted
    if ((lock_q == streamer_pkg::OWNER_X) && x_req_i.req) sel = streamer_pkg::OWNER_X;
    else if ((lock_q == streamer_pkg::OWNER_W) && w_req_i.req) sel = streamer_pkg::OWNER_W;
    // Store beats everything else
    else if (z_req_i.req) sel = streamer_pkg::OWNER_Z;
    else if (x_req_i.req && w_req_i.req) begin
      sel = rr_w_q ? streamer_pkg::OWNER_W : streamer_pkg::OWNER_X;
    end
    else if (x_req_i.req) sel = streamer_pkg::OWNER_X;
    else if (w_req_i.req) sel = streamer_pkg::OWNER_W;
  end

  always_comb begin
    case (sel)
      streamer_pkg::OWNER_X: mem_req_o = x_req_i;
      streamer_pkg::OWNER_W: mem_req_o = w_req_i;
      streamer_pkg::OWNER_Z: mem_req_o = z_req_i;
      default:               mem_req_o = '0;
    endcase
  end

  assign accepted = mem_req_o.req && mem_rsp_i.gnt;

  // gnt goes to the selected source only and read data to the registered owner
  // Store takes no read data
  always_comb begin
    x_rsp_o         = '0;
    w_rsp_o         = '0;
    z_rsp_o         = '0;
    x_rsp_o.gnt     = mem_rsp_i.gnt && (sel == streamer_pkg::OWNER_X);
    w_rsp_o.gnt     = mem_rsp_i.gnt && (sel == streamer_pkg::OWNER_W);
    z_rsp_o.gnt     = mem_rsp_i.gnt && (sel == streamer_pkg::OWNER_Z);
    x_rsp_o.r_valid = mem_rsp_i.r_valid && (rd_owner_q == streamer_pkg::OWNER_X);
    w_rsp_o.r_valid = mem_rsp_i.r_valid && (rd_owner_q == streamer_pkg::OWNER_W);
    x_rsp_o.r_data  = mem_rsp_i.r_data;
    w_rsp_o.r_data  = mem_rsp_i.r_data;
    z_rsp_o.r_data  = mem_rsp_i.r_data;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q     <= streamer_pkg::OWNER_NONE;
      rd_owner_q <= streamer_pkg::OWNER_NONE;
      rr_w_q     <= 1'b0;
    end else if (clear_i) begin
      lock_q     <= streamer_pkg::OWNER_NONE;
      rd_owner_q <= streamer_pkg::OWNER_NONE;
      rr_w_q     <= 1'b0;
    end else begin
      lock_q     <= (mem_req_o.req && !mem_rsp_i.gnt) ? sel : streamer_pkg::OWNER_NONE;
      rd_owner_q <= (accepted && mem_req_o.wen) ? sel : streamer_pkg::OWNER_NONE;
      // Pointer moves to the other load after a granted load
      if (accepted && (sel == streamer_pkg::OWNER_X)) rr_w_q <= 1'b1;
      else if (accepted && (sel == streamer_pkg::OWNER_W)) rr_w_q <= 1'b0;
    end
  end

  // A waiting request keeps every field on the port until it is granted
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !clear_i && mem_req_o.req && !mem_rsp_i.gnt |=> clear_i || $stable(mem_req_o))
    else $error("tcdm_arbiter: request changed before its grant");

  // Owner routing relies on the fixed one cycle read latency
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accepted && mem_req_o.wen |=> mem_rsp_i.r_valid)
    else $error("tcdm_arbiter: read data missing one cycle after grant");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the streamer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f all.f --top-module streamer_tb \
  -Mdir "$OBJ" -o streamer_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/streamer_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
